//--- dwb_cfg_pkg.sv
package dwb_cfg_pkg;

    // bus and line geometry
    localparam int ADDR_W   = 32;
    localparam int LINE_W   = 128;
    localparam int OFFSET_W = 4;
    localparam int TAG_W    = ADDR_W - OFFSET_W;

    // queue geometry
    localparam int DEPTH = 4;
    localparam int IDX_W = $clog2(DEPTH);

    // one address word, seen as a raw bus address or as tag plus offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [OFFSET_W-1:0] offset;
        } fields;
    } line_addr_u;

endpackage

//--- dwb_axil_pkg.sv
package dwb_axil_pkg;

    // channel widths
    localparam int AXI_DATA_W = 32;
    localparam int STRB_W     = AXI_DATA_W / 8;
    localparam int RESP_W     = 2;

    // response codes
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    // a line goes out as this many word writes
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);

    // writer FSM states
    localparam logic [1:0] WR_IDLE = 2'd0;
    localparam logic [1:0] WR_SEND = 2'd1;
    localparam logic [1:0] WR_RESP = 2'd2;

endpackage

//--- dwb_line_ram.sv
`timescale 1ns/10ps

module dwb_line_ram (
    input  logic                           clk,
    input  logic                           we_i,
    input  logic [dwb_cfg_pkg::IDX_W-1:0]  waddr_i,
    input  logic [dwb_cfg_pkg::LINE_W-1:0] wdata_i,
    input  logic [dwb_cfg_pkg::IDX_W-1:0]  raddr0_i,
    output logic [dwb_cfg_pkg::LINE_W-1:0] rdata0_o,
    input  logic [dwb_cfg_pkg::IDX_W-1:0]  raddr1_i,
    output logic [dwb_cfg_pkg::LINE_W-1:0] rdata1_o
);

    // one line per queue slot
    logic [dwb_cfg_pkg::LINE_W-1:0] mem [dwb_cfg_pkg::DEPTH];

    // single synchronous write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // port 0 serves cache reads, port 1 the head line for the writer
    assign rdata0_o = mem[raddr0_i];
    assign rdata1_o = mem[raddr1_i];

endmodule

//--- dwb_addr_cam.sv
`timescale 1ns/10ps

module dwb_addr_cam (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alloc_i,
    input  logic                              free_i,
    input  logic [dwb_cfg_pkg::IDX_W-1:0]     tail_i,
    input  logic [dwb_cfg_pkg::IDX_W-1:0]     head_i,
    input  dwb_cfg_pkg::line_addr_u           wr_addr_i,
    input  logic                              rd_req_i,
    input  dwb_cfg_pkg::line_addr_u           rd_addr_i,
    output logic [dwb_cfg_pkg::DEPTH-1:0]     wr_match_o,
    output logic                              rd_hit_o,
    output logic [dwb_cfg_pkg::IDX_W-1:0]     rd_idx_o,
    output logic [dwb_cfg_pkg::TAG_W-1:0]     head_tag_o,
    output logic                              full_o,
    output logic                              empty_o
);

    logic [dwb_cfg_pkg::TAG_W-1:0] tag_q [dwb_cfg_pkg::DEPTH];
    logic [dwb_cfg_pkg::DEPTH-1:0] valid_q;
    logic [dwb_cfg_pkg::DEPTH-1:0] rd_hit_q;

    // free first so an alloc to the same slot wins
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            if (free_i) begin
                valid_q[head_i] <= 1'b0;
            end
            if (alloc_i) begin
                valid_q[tail_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            tag_q[tail_i] <= wr_addr_i.fields.tag;
        end
    end

    // write lookup, same cycle
    always_comb begin
        for (int i = 0; i < dwb_cfg_pkg::DEPTH; i++) begin
            wr_match_o[i] = valid_q[i] && (tag_q[i] == wr_addr_i.fields.tag);
        end
    end

    // read lookup, answered one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hit_q <= '0;
        end else begin
            for (int i = 0; i < dwb_cfg_pkg::DEPTH; i++) begin
                rd_hit_q[i] <= rd_req_i && valid_q[i] && (tag_q[i] == rd_addr_i.fields.tag);
            end
        end
    end

    // tags are unique, so at most one bit is set
    always_comb begin
        rd_idx_o = '0;
        for (int i = 0; i < dwb_cfg_pkg::DEPTH; i++) begin
            if (rd_hit_q[i]) begin
                rd_idx_o = dwb_cfg_pkg::IDX_W'(i);
            end
        end
    end

    assign rd_hit_o   = |rd_hit_q;
    assign head_tag_o = tag_q[head_i];

    // tail slot still taken means no room left
    assign full_o  = valid_q[tail_i];
    assign empty_o = ~valid_q[head_i];

endmodule

//--- dwb_axil_writer.sv
`timescale 1ns/10ps

module dwb_axil_writer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start_i,
    input  logic [dwb_cfg_pkg::TAG_W-1:0]        line_addr_i,
    input  logic [dwb_cfg_pkg::LINE_W-1:0]       line_data_i,
    output logic                                 line_done_o,
    output logic                                 drain_active_o,
    // AXI4-Lite write channels
    output logic                                 m_awvalid_o,
    input  logic                                 m_awready_i,
    output logic [dwb_cfg_pkg::ADDR_W-1:0]       m_awaddr_o,
    output logic                                 m_wvalid_o,
    input  logic                                 m_wready_i,
    output logic [dwb_axil_pkg::AXI_DATA_W-1:0]  m_wdata_o,
    output logic [dwb_axil_pkg::STRB_W-1:0]      m_wstrb_o,
    input  logic                                 m_bvalid_i,
    input  logic [dwb_axil_pkg::RESP_W-1:0]      m_bresp_i,
    output logic                                 m_bready_o
);

    logic [1:0]                            state_q;
    logic [dwb_axil_pkg::WORD_IDX_W-1:0]   word_q;
    logic [dwb_axil_pkg::WORD_IDX_W-1:0]   next_word;
    logic                                  aw_done_q;
    logic                                  w_done_q;
    logic [dwb_cfg_pkg::ADDR_W-1:0]        awaddr_q;
    logic [dwb_axil_pkg::AXI_DATA_W-1:0]   wdata_q;
    dwb_cfg_pkg::line_addr_u               word_addr;
    logic                                  b_hs;
    logic                                  last_word;
    logic                                  load_word;

    assign b_hs      = (state_q == dwb_axil_pkg::WR_RESP) && m_bvalid_i;
    assign last_word = word_q == dwb_axil_pkg::WORD_IDX_W'(dwb_axil_pkg::WORDS_PER_LINE - 1);
    // bresp is ignored and any response completes the word
    assign line_done_o = b_hs && last_word;

    // payload is captured on entry to SEND and held until both handshakes
    assign load_word = ((state_q == dwb_axil_pkg::WR_IDLE) && start_i) || (b_hs && !last_word);
    assign next_word = (state_q == dwb_axil_pkg::WR_IDLE) ? '0 : word_q + 1'b1;

    // word address from the line tag and the offset of word k
    always_comb begin
        word_addr.fields.tag    = line_addr_i;
        word_addr.fields.offset = {next_word, 2'b00};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= dwb_axil_pkg::WR_IDLE;
            word_q    <= '0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                dwb_axil_pkg::WR_IDLE: begin
                    if (start_i) begin
                        state_q   <= dwb_axil_pkg::WR_SEND;
                        word_q    <= '0;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end
                end
                dwb_axil_pkg::WR_SEND: begin
                    // AW and W may complete in either order
                    if (m_awready_i) begin
                        aw_done_q <= 1'b1;
                    end
                    if (m_wready_i) begin
                        w_done_q <= 1'b1;
                    end
                    if ((aw_done_q || m_awready_i) && (w_done_q || m_wready_i)) begin
                        state_q <= dwb_axil_pkg::WR_RESP;
                    end
                end
                dwb_axil_pkg::WR_RESP: begin
                    if (m_bvalid_i) begin
                        if (last_word) begin
                            state_q <= dwb_axil_pkg::WR_IDLE;
                        end else begin
                            state_q   <= dwb_axil_pkg::WR_SEND;
                            word_q    <= next_word;
                            aw_done_q <= 1'b0;
                            w_done_q  <= 1'b0;
                        end
                    end
                end
                default: begin
                    state_q <= dwb_axil_pkg::WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_word) begin
            awaddr_q <= word_addr.raw;
            wdata_q  <= line_data_i[next_word*dwb_axil_pkg::AXI_DATA_W +: dwb_axil_pkg::AXI_DATA_W];
        end
    end

    assign m_awvalid_o    = (state_q == dwb_axil_pkg::WR_SEND) && !aw_done_q;
    assign m_wvalid_o     = (state_q == dwb_axil_pkg::WR_SEND) && !w_done_q;
    assign m_bready_o     = state_q == dwb_axil_pkg::WR_RESP;
    assign m_awaddr_o     = awaddr_q;
    assign m_wdata_o      = wdata_q;
    // whole words only
    assign m_wstrb_o      = '1;
    assign drain_active_o = state_q != dwb_axil_pkg::WR_IDLE;

endmodule

//--- dwb_ctrl.sv
`timescale 1ns/10ps

module dwb_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cpu_wreq_i,
    input  logic [dwb_cfg_pkg::LINE_W-1:0] cpu_wdata_i,
    input  logic [dwb_cfg_pkg::DEPTH-1:0]  wr_match_i,
    input  logic                           full_i,
    input  logic                           empty_i,
    input  logic                           line_done_i,
    input  logic                           drain_active_i,
    output logic                           alloc_o,
    output logic                           free_o,
    output logic [dwb_cfg_pkg::IDX_W-1:0]  head_o,
    output logic [dwb_cfg_pkg::IDX_W-1:0]  tail_o,
    output logic                           ram_we_o,
    output logic [dwb_cfg_pkg::IDX_W-1:0]  ram_waddr_o,
    output logic [dwb_cfg_pkg::LINE_W-1:0] ram_wdata_o,
    output logic                           start_o,
    output logic                           write_hit_o
);

    logic [dwb_cfg_pkg::IDX_W-1:0] head_q;
    logic [dwb_cfg_pkg::IDX_W-1:0] tail_q;
    logic [dwb_cfg_pkg::IDX_W-1:0] hit_idx;
    logic                          hit_any;
    logic                          head_hit;
    logic                          rewrite_set;
    logic                          rewrite_q;

    // slot index of the matching entry
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < dwb_cfg_pkg::DEPTH; i++) begin
            if (wr_match_i[i]) begin
                hit_idx = dwb_cfg_pkg::IDX_W'(i);
            end
        end
    end

    assign hit_any     = |wr_match_i;
    assign write_hit_o = cpu_wreq_i && hit_any;
    assign alloc_o     = cpu_wreq_i && !hit_any && !full_i;

    // merge into the hit slot or fill the tail, RAM takes it at the next edge
    assign ram_we_o    = write_hit_o || alloc_o;
    assign ram_waddr_o = hit_any ? hit_idx : tail_q;
    assign ram_wdata_o = cpu_wdata_i;

    // cache writing into the line at head
    assign head_hit    = cpu_wreq_i && wr_match_i[head_q];
    assign rewrite_set = head_hit && drain_active_i;

    // word 0 is latched when the writer leaves idle, so wait out a head merge
    assign start_o = !empty_i && !drain_active_i && !head_hit;

    // replay the head line if it changed while it was going out
    assign free_o = line_done_i && !rewrite_q && !rewrite_set;

    always_ff @(posedge clk) begin
        if (rst) begin
            rewrite_q <= 1'b0;
        end else if (line_done_i) begin
            rewrite_q <= 1'b0;
        end else if (rewrite_set) begin
            rewrite_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (alloc_o) begin
                tail_q <= tail_q + 1'b1;
            end
            if (free_o) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

endmodule

//--- dwb_top.sv
`timescale 1ns/10ps

module dwb_top (
    input  logic                                 clk,
    input  logic                                 rst,
    // cache write request
    input  logic                                 cpu_wreq_i,
    input  logic [dwb_cfg_pkg::ADDR_W-1:0]       cpu_awaddr_i,
    input  logic [dwb_cfg_pkg::LINE_W-1:0]       cpu_wdata_i,
    output logic                                 write_hit_o,
    // cache read request
    input  logic                                 cpu_rreq_i,
    input  logic [dwb_cfg_pkg::ADDR_W-1:0]       cpu_araddr_i,
    output logic                                 read_hit_o,
    output logic [dwb_cfg_pkg::LINE_W-1:0]       cpu_rdata_o,
    // queue status
    output logic                                 full_o,
    output logic                                 empty_o,
    // AXI4-Lite write master
    output logic                                 m_awvalid_o,
    input  logic                                 m_awready_i,
    output logic [dwb_cfg_pkg::ADDR_W-1:0]       m_awaddr_o,
    output logic                                 m_wvalid_o,
    input  logic                                 m_wready_i,
    output logic [dwb_axil_pkg::AXI_DATA_W-1:0]  m_wdata_o,
    output logic [dwb_axil_pkg::STRB_W-1:0]      m_wstrb_o,
    input  logic                                 m_bvalid_i,
    input  logic [dwb_axil_pkg::RESP_W-1:0]      m_bresp_i,
    output logic                                 m_bready_o
);

    logic                           alloc;
    logic                           free;
    logic [dwb_cfg_pkg::IDX_W-1:0]  head;
    logic [dwb_cfg_pkg::IDX_W-1:0]  tail;
    logic [dwb_cfg_pkg::DEPTH-1:0]  wr_match;
    logic [dwb_cfg_pkg::IDX_W-1:0]  rd_idx;
    logic [dwb_cfg_pkg::TAG_W-1:0]  head_tag;
    logic                           ram_we;
    logic [dwb_cfg_pkg::IDX_W-1:0]  ram_waddr;
    logic [dwb_cfg_pkg::LINE_W-1:0] ram_wdata;
    logic [dwb_cfg_pkg::LINE_W-1:0] head_line;
    logic                           start;
    logic                           line_done;
    logic                           drain_active;

    dwb_ctrl dwb_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .cpu_wreq_i     (cpu_wreq_i),
        .cpu_wdata_i    (cpu_wdata_i),
        .wr_match_i     (wr_match),
        .full_i         (full_o),
        .empty_i        (empty_o),
        .line_done_i    (line_done),
        .drain_active_i (drain_active),
        .alloc_o        (alloc),
        .free_o         (free),
        .head_o         (head),
        .tail_o         (tail),
        .ram_we_o       (ram_we),
        .ram_waddr_o    (ram_waddr),
        .ram_wdata_o    (ram_wdata),
        .start_o        (start),
        .write_hit_o    (write_hit_o)
    );

    dwb_addr_cam dwb_addr_cam_i (
        .clk        (clk),
        .rst        (rst),
        .alloc_i    (alloc),
        .free_i     (free),
        .tail_i     (tail),
        .head_i     (head),
        .wr_addr_i  (cpu_awaddr_i),
        .rd_req_i   (cpu_rreq_i),
        .rd_addr_i  (cpu_araddr_i),
        .wr_match_o (wr_match),
        .rd_hit_o   (read_hit_o),
        .rd_idx_o   (rd_idx),
        .head_tag_o (head_tag),
        .full_o     (full_o),
        .empty_o    (empty_o)
    );

    dwb_line_ram dwb_line_ram_i (
        .clk      (clk),
        .we_i     (ram_we),
        .waddr_i  (ram_waddr),
        .wdata_i  (ram_wdata),
        .raddr0_i (rd_idx),
        .rdata0_o (cpu_rdata_o),
        .raddr1_i (head),
        .rdata1_o (head_line)
    );

    dwb_axil_writer dwb_axil_writer_i (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start),
        .line_addr_i    (head_tag),
        .line_data_i    (head_line),
        .line_done_o    (line_done),
        .drain_active_o (drain_active),
        .m_awvalid_o    (m_awvalid_o),
        .m_awready_i    (m_awready_i),
        .m_awaddr_o     (m_awaddr_o),
        .m_wvalid_o     (m_wvalid_o),
        .m_wready_i     (m_wready_i),
        .m_wdata_o      (m_wdata_o),
        .m_wstrb_o      (m_wstrb_o),
        .m_bvalid_i     (m_bvalid_i),
        .m_bresp_i      (m_bresp_i),
        .m_bready_o     (m_bready_o)
    );

endmodule

//--- tb_dwb_top.sv
`timescale 1ns/10ps

module tb_dwb_top;

    localparam int NUM_OPS    = 2000;
    localparam int MAX_CYCLES = NUM_OPS * 40;
    localparam int NUM_TAGS   = 8;
    localparam int DEPTH      = dwb_cfg_pkg::DEPTH;
    localparam logic [31:0] BASE_ADDR = 32'h0004_2000;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                                 clk;
    logic                                 rst;
    logic                                 cpu_wreq;
    logic [dwb_cfg_pkg::ADDR_W-1:0]       cpu_awaddr;
    logic [dwb_cfg_pkg::LINE_W-1:0]       cpu_wdata;
    logic                                 write_hit;
    logic                                 cpu_rreq;
    logic [dwb_cfg_pkg::ADDR_W-1:0]       cpu_araddr;
    logic                                 read_hit;
    logic [dwb_cfg_pkg::LINE_W-1:0]       cpu_rdata;
    logic                                 full;
    logic                                 empty;
    logic                                 m_awvalid;
    logic                                 m_awready;
    logic [dwb_cfg_pkg::ADDR_W-1:0]       m_awaddr;
    logic                                 m_wvalid;
    logic                                 m_wready;
    logic [dwb_axil_pkg::AXI_DATA_W-1:0]  m_wdata;
    logic [dwb_axil_pkg::STRB_W-1:0]      m_wstrb;
    logic                                 m_bvalid;
    logic [dwb_axil_pkg::RESP_W-1:0]      m_bresp;
    logic                                 m_bready;

    // queue model slot by slot
    logic [dwb_cfg_pkg::TAG_W-1:0]  q_tag   [DEPTH];
    logic [dwb_cfg_pkg::LINE_W-1:0] q_data  [DEPTH];
    logic                           q_valid [DEPTH];
    logic [dwb_cfg_pkg::IDX_W-1:0]  q_head;
    logic [dwb_cfg_pkg::IDX_W-1:0]  q_tail;
    int                             q_count;

    // memory behind the AXI slave and the newest line per tag
    logic [31:0]                    mem_word  [NUM_TAGS*4];
    logic [dwb_cfg_pkg::LINE_W-1:0] last_line [NUM_TAGS];
    logic                           written   [NUM_TAGS];
    logic [2:0]                     wr_tidx;

    // drain tracking from port activity
    logic                           in_line;
    logic                           rewrite;
    logic [1:0]                     word_k;
    logic [dwb_cfg_pkg::LINE_W-1:0] exp_line;
    logic [dwb_cfg_pkg::LINE_W-1:0] start_line;
    logic                           aw_open;
    logic                           aw_got;
    logic                           w_got;
    logic                           b_due;
    logic [31:0]                    aw_addr;
    logic [31:0]                    w_data;
    int                             aw_delay;
    int                             w_delay;
    int                             b_delay;
    bit                             aw_armed;
    bit                             w_armed;
    bit                             b_armed;

    logic                           rd_exp_hit;
    logic [dwb_cfg_pkg::LINE_W-1:0] rd_exp_data;
    logic [31:0]                    lfsr;
    int wr_errs;
    int rd_errs;
    int st_errs;
    int axi_errs;
    int mem_errs;
    int lines_done;
    int replays;
    int cycle_count = 0;

    dwb_top dwb_top_i (
        .clk          (clk),
        .rst          (rst),
        .cpu_wreq_i   (cpu_wreq),
        .cpu_awaddr_i (cpu_awaddr),
        .cpu_wdata_i  (cpu_wdata),
        .write_hit_o  (write_hit),
        .cpu_rreq_i   (cpu_rreq),
        .cpu_araddr_i (cpu_araddr),
        .read_hit_o   (read_hit),
        .cpu_rdata_o  (cpu_rdata),
        .full_o       (full),
        .empty_o      (empty),
        .m_awvalid_o  (m_awvalid),
        .m_awready_i  (m_awready),
        .m_awaddr_o   (m_awaddr),
        .m_wvalid_o   (m_wvalid),
        .m_wready_i   (m_wready),
        .m_wdata_o    (m_wdata),
        .m_wstrb_o    (m_wstrb),
        .m_bvalid_i   (m_bvalid),
        .m_bresp_i    (m_bresp),
        .m_bready_o   (m_bready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the buffer did not drain", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] line_addr(input logic [2:0] t);
        return BASE_ADDR + {25'd0, t, 4'd0};
    endfunction

    // model slot holding this line or -1
    function automatic int find_slot(input logic [31:0] addr);
        dwb_cfg_pkg::line_addr_u la;
        int                      slot;
        la   = addr;
        slot = -1;
        for (int i = 0; i < DEPTH; i++) begin
            if (q_valid[i] && q_tag[i] == la.fields.tag) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    // slave side handshake with a random 0 to 3 cycle delay
    task automatic pace_ready(input logic valid, inout int delay, inout bit armed,
                              output logic ready);
        ready = 1'b0;
        if (!valid) begin
            armed = 1'b0;
        end else begin
            if (!armed) begin
                delay = int'(rand_bits(2));
                armed = 1'b1;
            end
            if (delay == 0) begin
                ready = 1'b1;
            end else begin
                delay = delay - 1;
            end
        end
    endtask

    task automatic check_outputs();
        if (full !== (q_count == DEPTH)) begin
            $display("** Error at %0t: full_o is %b, model count %0d", $time, full, q_count);
            st_errs++;
        end
        if (empty !== (q_count == 0)) begin
            $display("** Error at %0t: empty_o is %b, model count %0d", $time, empty, q_count);
            st_errs++;
        end
        if (read_hit !== rd_exp_hit) begin
            $display("** Error at %0t: read_hit_o is %b, expected %b", $time, read_hit,
                     rd_exp_hit);
            rd_errs++;
        end else if (rd_exp_hit && cpu_rdata !== rd_exp_data) begin
            $display("** Error at %0t: cpu_rdata_o %h, expected %h", $time, cpu_rdata,
                     rd_exp_data);
            rd_errs++;
        end
        if (m_awvalid && aw_open) begin
            $display("** Error at %0t: AW raised before the previous B", $time);
            axi_errs++;
        end
        // first AW of a line opens the drain window
        if (m_awvalid && !in_line) begin
            in_line  = 1'b1;
            word_k   = 2'd0;
            exp_line = start_line;
        end
    endtask

    task automatic drive_inputs(input bit issue);
        logic [1:0]  op;
        logic [2:0]  t;
        logic [31:0] offs;
        cpu_wreq = 1'b0;
        cpu_rreq = 1'b0;
        pace_ready(m_awvalid, aw_delay, aw_armed, m_awready);
        pace_ready(m_wvalid, w_delay, w_armed, m_wready);
        pace_ready(b_due, b_delay, b_armed, m_bvalid);
        if (issue) begin
            op = 2'(rand_bits(2));
            t  = 3'(rand_bits(3));
            if (op == 2'd1) begin
                offs       = rand_bits(4);
                cpu_rreq   = 1'b1;
                cpu_araddr = line_addr(t) | offs;
            end else if (op[1]) begin
                // a miss needs a free slot
                if (find_slot(line_addr(t)) >= 0 || q_count < DEPTH) begin
                    cpu_wreq   = 1'b1;
                    cpu_awaddr = line_addr(t);
                    cpu_wdata  = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
                    wr_tidx    = t;
                end
            end
        end
    endtask

    // everything that happens at the coming rising edge
    task automatic observe_edge();
        logic [dwb_cfg_pkg::LINE_W-1:0] pre_line;
        logic [31:0]                    exp_addr;
        logic [31:0]                    offs;
        int                             slot;
        int                             rslot;
        logic                           head_hit;

        pre_line = q_data[q_head];
        slot     = find_slot(cpu_awaddr);
        head_hit = cpu_wreq && (slot == int'(q_head));

        if (write_hit !== (cpu_wreq && slot >= 0)) begin
            $display("** Error at %0t: write_hit_o is %b, expected %b", $time, write_hit,
                     cpu_wreq && slot >= 0);
            wr_errs++;
        end

        rd_exp_hit = 1'b0;
        if (cpu_rreq) begin
            rslot = find_slot(cpu_araddr);
            if (rslot >= 0) begin
                rd_exp_hit  = 1'b1;
                rd_exp_data = q_data[dwb_cfg_pkg::IDX_W'(rslot)];
            end
        end

        if (m_awvalid && m_awready) begin
            // line base address plus four bytes per word
            exp_addr = {q_tag[q_head], 4'd0} + 32'(word_k) * 32'd4;
            if (m_awaddr !== exp_addr) begin
                $display("** Error at %0t: awaddr %h, expected %h", $time, m_awaddr,
                         exp_addr);
                axi_errs++;
            end
            aw_got  = 1'b1;
            aw_open = 1'b1;
            aw_addr = m_awaddr;
        end
        if (m_wvalid && m_wready) begin
            if (m_wdata !== exp_line[word_k*32 +: 32]) begin
                $display("** Error at %0t: wdata %h, expected %h for word %0d", $time,
                         m_wdata, exp_line[word_k*32 +: 32], word_k);
                axi_errs++;
            end
            if (m_wstrb !== '1) begin
                $display("** Error at %0t: wstrb %b, expected all ones", $time, m_wstrb);
                axi_errs++;
            end
            w_got  = 1'b1;
            w_data = m_wdata;
        end
        if (aw_got && w_got) begin
            offs = aw_addr - BASE_ADDR;
            if (offs < 32'd128) begin
                mem_word[offs[6:2]] = w_data;
            end
            aw_got = 1'b0;
            w_got  = 1'b0;
            b_due  = 1'b1;
        end

        // head line changed while going out
        if (in_line && head_hit) begin
            rewrite = 1'b1;
        end
        if (m_bvalid && m_bready) begin
            b_due   = 1'b0;
            aw_open = 1'b0;
            if (word_k == 2'd3) begin
                in_line = 1'b0;
                word_k  = 2'd0;
                lines_done++;
                if (rewrite) begin
                    rewrite = 1'b0;
                    replays++;
                end else begin
                    q_valid[q_head] = 1'b0;
                    q_head          = q_head + 1'b1;
                    q_count--;
                end
            end else begin
                word_k   = word_k + 2'd1;
                exp_line = pre_line;
            end
        end

        if (cpu_wreq) begin
            if (slot >= 0) begin
                q_data[dwb_cfg_pkg::IDX_W'(slot)] = cpu_wdata;
            end else begin
                q_tag[q_tail]   = cpu_awaddr[dwb_cfg_pkg::ADDR_W-1:dwb_cfg_pkg::OFFSET_W];
                q_data[q_tail]  = cpu_wdata;
                q_valid[q_tail] = 1'b1;
                q_tail          = q_tail + 1'b1;
                q_count++;
            end
            last_line[wr_tidx] = cpu_wdata;
            written[wr_tidx]   = 1'b1;
        end
        start_line = pre_line;
    endtask

    task automatic run_cycle(input bit issue);
        @(negedge clk);
        check_outputs();
        drive_inputs(issue);
        #1;
        observe_edge();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cpu_wreq   = 1'b0;
        cpu_awaddr = '0;
        cpu_wdata  = '0;
        cpu_rreq   = 1'b0;
        cpu_araddr = '0;
        m_awready  = 1'b0;
        m_wready   = 1'b0;
        m_bvalid   = 1'b0;
        m_bresp    = dwb_axil_pkg::RESP_OKAY;
        lfsr       = 32'h990a3848;
        q_head     = '0;
        q_tail     = '0;
        q_count    = 0;
        for (int i = 0; i < DEPTH; i++) begin
            q_valid[i] = 1'b0;
            q_tag[i]   = '0;
            q_data[i]  = '0;
        end
        // each word starts as the inverse of its address
        for (int i = 0; i < NUM_TAGS * 4; i++) begin
            mem_word[i] = ~(BASE_ADDR + 32'(i * 4));
        end
        for (int i = 0; i < NUM_TAGS; i++) begin
            written[i]   = 1'b0;
            last_line[i] = '0;
        end
        wr_tidx     = '0;
        in_line     = 1'b0;
        rewrite     = 1'b0;
        word_k      = 2'd0;
        exp_line    = '0;
        start_line  = '0;
        aw_open     = 1'b0;
        aw_got      = 1'b0;
        w_got       = 1'b0;
        b_due       = 1'b0;
        aw_addr     = '0;
        w_data      = '0;
        aw_delay    = 0;
        w_delay     = 0;
        b_delay     = 0;
        aw_armed    = 1'b0;
        w_armed     = 1'b0;
        b_armed     = 1'b0;
        rd_exp_hit  = 1'b0;
        rd_exp_data = '0;
        wr_errs     = 0;
        rd_errs     = 0;
        st_errs     = 0;
        axi_errs    = 0;
        mem_errs    = 0;
        lines_done  = 0;
        replays     = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (empty !== 1'b1 || full !== 1'b0) begin
            $display("** Error at %0t: status after reset full %b empty %b", $time, full, empty);
            st_errs++;
        end
        if ({m_awvalid, m_wvalid, m_bready, read_hit, write_hit} !== 5'b0) begin
            $display("** Error at %0t: valid or hit output high after reset", $time);
            st_errs++;
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            run_cycle(1'b1);
        end
        while (q_count != 0 || in_line) begin
            run_cycle(1'b0);
        end
        repeat (2) run_cycle(1'b0);

        if (empty !== 1'b1) begin
            $display("** Error at %0t: empty_o low after the final drain", $time);
            st_errs++;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (written[t]) begin
                for (int k = 0; k < 4; k++) begin
                    if (mem_word[t*4+k] !== last_line[t][k*32 +: 32]) begin
                        $display("** Error at %0t: memory line %0d word %0d is %h, expected %h",
                                 $time, t, k, mem_word[t*4+k], last_line[t][k*32 +: 32]);
                        mem_errs++;
                    end
                end
            end
        end

        $display("lines drained %0d, replayed %0d", lines_done, replays);
        $display("errors: write %0d, read %0d, status %0d, axi %0d, memory %0d",
                 wr_errs, rd_errs, st_errs, axi_errs, mem_errs);
        if (wr_errs + rd_errs + st_errs + axi_errs + mem_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- dwb_top.f
dwb_cfg_pkg.sv
dwb_axil_pkg.sv
dwb_line_ram.sv
dwb_addr_cam.sv
dwb_axil_writer.sv
dwb_ctrl.sv
dwb_top.sv
tb_dwb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the write-back buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f dwb_top.f \
    --top-module tb_dwb_top -o tb_dwb_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dwb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
